// File: Bender.yml
package:
  name: rv32i_multicycle_core

sources:
  - files:
      - design/core_pkg.sv
      - design/inst_decoder.sv
      - design/alu.sv
      - design/reg_file.sv
      - design/unified_memory.sv
      - design/core_control.sv
      - design/core_top.sv
  - target: test
    files:
      - tests/core_assert.sv
      - tests/core_tb.sv

// File: design/alu.sv
`timescale 1ns/1ns

module alu (
    input  core_pkg::xlen_t   a,
    input  core_pkg::xlen_t   b,
    input  core_pkg::alu_op_t op,
    output core_pkg::xlen_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            core_pkg::ALU_ADD:
                result = a + b;
            core_pkg::ALU_SUB:
                result = a - b;
            core_pkg::ALU_AND:
                result = a & b;
            core_pkg::ALU_OR:
                result = a | b;
            core_pkg::ALU_XOR:
                result = a ^ b;
            core_pkg::ALU_SLL:
                result = a << shamt;
            core_pkg::ALU_SRL:
                result = a >> shamt;
            // Sign bit fills from the left
            core_pkg::ALU_SRA:
                result = core_pkg::xlen_t'($signed(a) >>> shamt);
            default:
                result = '0;
        endcase
    end

endmodule

// File: design/core_control.sv
`timescale 1ns/1ns

module core_control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  core_pkg::xlen_t     imem_rdata,
    input  core_pkg::xlen_t     dmem_rdata,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::xlen_t     imm,
    input  core_pkg::alu_op_t   alu_op,
    input  logic                use_imm,
    input  logic                is_load,
    input  logic                is_store,
    input  logic                rd_we,
    input  core_pkg::xlen_t     rs1_data,
    input  core_pkg::xlen_t     rs2_data,
    output logic                rf_we,
    output core_pkg::reg_addr_t rf_waddr,
    output core_pkg::xlen_t     rf_wdata,
    output core_pkg::xlen_t     alu_a,
    output core_pkg::xlen_t     alu_b,
    input  core_pkg::xlen_t     alu_result,
    output core_pkg::xlen_t     imem_addr,
    output core_pkg::xlen_t     dmem_addr,
    output logic                dmem_we,
    output core_pkg::xlen_t     dmem_wdata,
    output core_pkg::inst_t     inst,
    output logic                retire_valid,
    output core_pkg::xlen_t     retire_pc,
    output logic                retire_rd_we,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::xlen_t     retire_data,
    output logic                retire_mem_we,
    output core_pkg::xlen_t     retire_mem_addr
);

    core_pkg::state_t state;
    core_pkg::xlen_t pc;
    core_pkg::xlen_t alu_q;
    core_pkg::xlen_t store_q;
    core_pkg::xlen_t rs1_val;
    core_pkg::xlen_t rs2_val;
    logic in_wb;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= core_pkg::ST_IF;
            pc <= '0;
            inst <= '0;
        end
        else
        begin
            case (state)
                core_pkg::ST_IF:
                begin
                    // Hold here until run goes high
                    if (run)
                    begin
                        state <= core_pkg::ST_ID;
                    end
                end
                core_pkg::ST_ID:
                begin
                    inst <= imem_rdata;
                    state <= core_pkg::ST_EX;
                end
                core_pkg::ST_EX:
                begin
                    state <= core_pkg::ST_MEM;
                end
                core_pkg::ST_MEM:
                begin
                    state <= core_pkg::ST_WB;
                end
                core_pkg::ST_WB:
                begin
                    pc <= pc + 32'd4;
                    state <= core_pkg::ST_IF;
                end
                default:
                begin
                    state <= core_pkg::ST_IF;
                end
            endcase
        end
    end

    // Operand selection, x0 forced to zero
    assign rs1_val = (rs1_addr == '0) ? '0 : rs1_data;
    assign rs2_val = (rs2_addr == '0) ? '0 : rs2_data;
    assign alu_a = rs1_val;
    assign alu_b = use_imm ? imm : rs2_val;

    always_ff @(posedge clk)
    begin
        if (state == core_pkg::ST_EX)
        begin
            alu_q <= alu_result;
            store_q <= rs2_val;
        end
    end

    assign imem_addr = pc;

    // Load address or store in MEM; load data returns in WB
    assign dmem_addr = alu_q;
    assign dmem_we = (state == core_pkg::ST_MEM) && is_store;
    assign dmem_wdata = store_q;

    assign in_wb = (state == core_pkg::ST_WB);

    assign rf_we = in_wb && rd_we;
    assign rf_waddr = rd_addr;
    assign rf_wdata = is_load ? dmem_rdata : alu_q;

    assign retire_valid = in_wb;
    assign retire_pc = pc;
    assign retire_rd_we = rf_we;
    assign retire_rd = rd_addr;
    assign retire_data = is_store ? store_q : rf_wdata;
    assign retire_mem_we = in_wb && is_store;
    assign retire_mem_addr = alu_q;

endmodule

// File: design/core_pkg.sv
package core_pkg;

    // Data word and byte address
    typedef logic [31:0] xlen_t;

    typedef logic [31:0] inst_t;

    typedef logic [4:0] reg_addr_t;

    // Word index into the unified memory
    typedef logic [7:0] mem_addr_t;

    localparam int MEM_WORDS = 256;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // funct3 fields of the supported subset
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SR = 3'b101;
    localparam logic [2:0] F3_OR = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    // funct7 values, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_IF,
        ST_ID,
        ST_EX,
        ST_MEM,
        ST_WB
    } state_t;

endpackage

// File: design/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  logic                prog_we,
    input  core_pkg::mem_addr_t prog_addr,
    input  core_pkg::xlen_t     prog_wdata,
    output logic                retire_valid,
    output core_pkg::xlen_t     retire_pc,
    output logic                retire_rd_we,
    output core_pkg::reg_addr_t retire_rd,
    output core_pkg::xlen_t     retire_data,
    output logic                retire_mem_we,
    output core_pkg::xlen_t     retire_mem_addr
);

    core_pkg::inst_t inst;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::reg_addr_t rd_addr;
    core_pkg::xlen_t imm;
    core_pkg::alu_op_t alu_op;
    logic use_imm;
    logic is_load;
    logic is_store;
    logic rd_we;
    core_pkg::xlen_t rs1_data;
    core_pkg::xlen_t rs2_data;
    logic rf_we;
    core_pkg::reg_addr_t rf_waddr;
    core_pkg::xlen_t rf_wdata;
    core_pkg::xlen_t alu_a;
    core_pkg::xlen_t alu_b;
    core_pkg::xlen_t alu_result;
    core_pkg::xlen_t imem_addr;
    core_pkg::xlen_t imem_rdata;
    core_pkg::xlen_t dmem_addr;
    core_pkg::xlen_t dmem_rdata;
    logic dmem_we;
    core_pkg::xlen_t dmem_wdata;

    core_control control0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (run),
        .imem_rdata      (imem_rdata),
        .dmem_rdata      (dmem_rdata),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .rd_addr         (rd_addr),
        .imm             (imm),
        .alu_op          (alu_op),
        .use_imm         (use_imm),
        .is_load         (is_load),
        .is_store        (is_store),
        .rd_we           (rd_we),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .alu_a           (alu_a),
        .alu_b           (alu_b),
        .alu_result      (alu_result),
        .imem_addr       (imem_addr),
        .dmem_addr       (dmem_addr),
        .dmem_we         (dmem_we),
        .dmem_wdata      (dmem_wdata),
        .inst            (inst),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_rd_we    (retire_rd_we),
        .retire_rd       (retire_rd),
        .retire_data     (retire_data),
        .retire_mem_we   (retire_mem_we),
        .retire_mem_addr (retire_mem_addr)
    );

    inst_decoder decoder0 (
        .inst     (inst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .imm      (imm),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .is_load  (is_load),
        .is_store (is_store),
        .rd_we    (rd_we)
    );

    reg_file regs0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .we       (rf_we),
        .waddr    (rf_waddr),
        .wdata    (rf_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu alu0 (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    unified_memory mem0 (
        .clk        (clk),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_we    (dmem_we),
        .dmem_wdata (dmem_wdata),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata)
    );

endmodule

// File: design/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  core_pkg::inst_t     inst,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    output core_pkg::reg_addr_t rd_addr,
    output core_pkg::xlen_t     imm,
    output core_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output logic                is_load,
    output logic                is_store,
    output logic                rd_we
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic plain_f7;
    logic alt_f7;
    logic writes;
    core_pkg::xlen_t imm_i;
    core_pkg::xlen_t imm_s;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd_addr = inst[11:7];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    assign plain_f7 = (funct7 == core_pkg::F7_BASE);
    assign alt_f7 = (funct7 == core_pkg::F7_ALT);

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    always_comb
    begin
        alu_op = core_pkg::ALU_ADD;
        imm = imm_i;
        use_imm = 1'b0;
        is_load = 1'b0;
        is_store = 1'b0;
        writes = 1'b0;
        case (opcode)
            core_pkg::OPC_LOAD:
            begin
                use_imm = 1'b1;
                is_load = (funct3 == core_pkg::F3_WORD);
                writes = is_load;
            end
            core_pkg::OPC_STORE:
            begin
                use_imm = 1'b1;
                imm = imm_s;
                is_store = (funct3 == core_pkg::F3_WORD);
            end
            core_pkg::OPC_OP, core_pkg::OPC_OP_IMM:
            begin
                use_imm = (opcode == core_pkg::OPC_OP_IMM);
                // Immediate forms ignore funct7 except on shifts
                case (funct3)
                    core_pkg::F3_ADD_SUB:
                    begin
                        alu_op = (!use_imm && alt_f7) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                        writes = use_imm || plain_f7 || alt_f7;
                    end
                    core_pkg::F3_SLL:
                    begin
                        alu_op = core_pkg::ALU_SLL;
                        writes = plain_f7;
                    end
                    core_pkg::F3_XOR:
                    begin
                        alu_op = core_pkg::ALU_XOR;
                        writes = use_imm || plain_f7;
                    end
                    core_pkg::F3_SR:
                    begin
                        alu_op = alt_f7 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                        writes = plain_f7 || alt_f7;
                    end
                    core_pkg::F3_OR:
                    begin
                        alu_op = core_pkg::ALU_OR;
                        writes = use_imm || plain_f7;
                    end
                    core_pkg::F3_AND:
                    begin
                        alu_op = core_pkg::ALU_AND;
                        writes = use_imm || plain_f7;
                    end
                    default:
                    begin
                        writes = 1'b0;
                    end
                endcase
            end
            default:
            begin
                writes = 1'b0;
            end
        endcase
    end

    assign rd_we = writes && (rd_addr != '0);

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::xlen_t     wdata,
    output core_pkg::xlen_t     rs1_data,
    output core_pkg::xlen_t     rs2_data
);

    core_pkg::xlen_t regs [32];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        // x0 never takes a write
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

// File: design/unified_memory.sv
`timescale 1ns/1ns

module unified_memory (
    input  logic                clk,
    input  core_pkg::xlen_t     imem_addr,
    input  core_pkg::xlen_t     dmem_addr,
    input  logic                dmem_we,
    input  core_pkg::xlen_t     dmem_wdata,
    input  logic                prog_we,
    input  core_pkg::mem_addr_t prog_addr,
    input  core_pkg::xlen_t     prog_wdata,
    output core_pkg::xlen_t     imem_rdata,
    output core_pkg::xlen_t     dmem_rdata
);

    core_pkg::xlen_t mem [core_pkg::MEM_WORDS];

    core_pkg::mem_addr_t i_index;
    core_pkg::mem_addr_t d_index;

    // Word select from byte address
    assign i_index = imem_addr[9:2];
    assign d_index = dmem_addr[9:2];

    always_ff @(posedge clk)
    begin
        if (prog_we)
        begin
            mem[prog_addr] <= prog_wdata;
        end
        else if (dmem_we)
        begin
            mem[d_index] <= dmem_wdata;
        end
    end

    // Both reads registered, data one cycle after address
    always_ff @(posedge clk)
    begin
        imem_rdata <= mem[i_index];
        dmem_rdata <= mem[d_index];
    end

endmodule

// File: flist.f
design/core_pkg.sv
design/inst_decoder.sv
design/alu.sv
design/reg_file.sv
design/unified_memory.sv
design/core_control.sv
design/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

// File: tests/core_assert.sv
`timescale 1ns/1ns

module core_assert (
    input logic                clk,
    input logic                rst_n,
    input logic                run,
    input core_pkg::state_t    state,
    input logic                retire_valid,
    input logic                retire_rd_we,
    input core_pkg::reg_addr_t retire_rd,
    input logic                retire_mem_we
);

    int unsigned fails = 0;

    // Write-back comes four cycles after a fetch that saw run high
    retire_in_wb: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> state == core_pkg::ST_WB
            && $past(state, 4) == core_pkg::ST_IF && $past(run, 4))
    else
    begin
        $error("Retire without a fetch under run four cycles earlier");
        fails++;
    end

    // Decode runs through execute and memory to a retire
    ex_after_id: assert property (@(posedge clk) disable iff (!rst_n)
        state == core_pkg::ST_ID |=> state == core_pkg::ST_EX
            ##1 state == core_pkg::ST_MEM ##1 retire_valid)
    else
    begin
        $error("Decode did not run through execute and memory to a retire");
        fails++;
    end

    // x0 never shows up as a written register
    rd_not_x0: assert property (@(posedge clk) disable iff (!rst_n)
        retire_rd_we |-> retire_rd != '0)
    else
    begin
        $error("Register write retired with rd of zero");
        fails++;
    end

    one_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(retire_mem_we && retire_rd_we))
    else
    begin
        $error("Store and register write retired together");
        fails++;
    end

endmodule

bind core_control core_assert assert0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .run           (run),
    .state         (state),
    .retire_valid  (retire_valid),
    .retire_rd_we  (retire_rd_we),
    .retire_rd     (retire_rd),
    .retire_mem_we (retire_mem_we)
);

// File: tests/core_tb.sv
`timescale 1ns/1ns

module core_tb;

    localparam int PERIOD = 100;
    // Instructions over all tests, five cycles each
    localparam int TOTAL_INSTS = 48;
    // Reset, program loading and the run pause
    localparam int SLACK_CYCLES = 600;

    logic clk;
    logic rst_n;
    logic run;
    logic prog_we;
    core_pkg::mem_addr_t prog_addr;
    core_pkg::xlen_t prog_wdata;
    logic retire_valid;
    core_pkg::xlen_t retire_pc;
    logic retire_rd_we;
    core_pkg::reg_addr_t retire_rd;
    core_pkg::xlen_t retire_data;
    logic retire_mem_we;
    core_pkg::xlen_t retire_mem_addr;

    core_pkg::inst_t prog [$];
    core_pkg::xlen_t model_regs [32];
    core_pkg::xlen_t model_mem [core_pkg::MEM_WORDS];
    core_pkg::xlen_t model_pc;
    int cycle = 0;
    int mark_cycle;
    int gap;
    int error_count = 0;

    core_top dut0 (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (run),
        .prog_we         (prog_we),
        .prog_addr       (prog_addr),
        .prog_wdata      (prog_wdata),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_rd_we    (retire_rd_we),
        .retire_rd       (retire_rd),
        .retire_data     (retire_data),
        .retire_mem_we   (retire_mem_we),
        .retire_mem_addr (retire_mem_addr)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    task automatic fail_run();
        error_count++;
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic compare(input string name, input core_pkg::xlen_t expected,
                           input core_pkg::xlen_t actual);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s expected %h, actual %h",
                     $time, name, expected, actual);
            fail_run();
        end
    endtask

    // Bound assertion module counts its failures
    always @(negedge clk)
    begin
        if (dut0.control0.assert0.fails != 0)
        begin
            $display("A concurrent assertion on core_control failed");
            fail_run();
        end
    end

    initial
    begin
        #(PERIOD * (TOTAL_INSTS * 5 + SLACK_CYCLES));
        $display("Watchdog expired, the core stopped retiring instructions");
        fail_run();
    end

    function automatic core_pkg::inst_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                               input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), core_pkg::OPC_OP};
    endfunction

    function automatic core_pkg::inst_t i_type(input int imm, input logic [2:0] f3,
                                               input int rd, input int rs1);
        return {12'(imm), 5'(rs1), f3, 5'(rd), core_pkg::OPC_OP_IMM};
    endfunction

    function automatic core_pkg::inst_t lw_inst(input int rd, input int rs1, input int off);
        return {12'(off), 5'(rs1), 3'b010, 5'(rd), core_pkg::OPC_LOAD};
    endfunction

    function automatic core_pkg::inst_t sw_inst(input int rs2, input int rs1, input int off);
        logic [11:0] o;
        o = 12'(off);
        return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], core_pkg::OPC_STORE};
    endfunction

    // Logical shift with the vacated top bits filled from the sign
    function automatic core_pkg::xlen_t shift_right_arith(input core_pkg::xlen_t v,
                                                          input logic [4:0] sh);
        core_pkg::xlen_t fill;
        fill = v[31] ? ~(32'hffff_ffff >> sh) : '0;
        return (v >> sh) | fill;
    endfunction

    task automatic reset_core();
        @(posedge clk);
        rst_n <= 1'b0;
        run <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        model_pc = '0;
        for (int r = 0; r < 32; r++)
        begin
            model_regs[r] = '0;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++)
        begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= 8'(i);
            prog_wdata <= prog[i];
            model_mem[i] = prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    // Marks the first IF cycle with run high
    task automatic raise_run();
        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        mark_cycle = cycle;
        gap = 4;
    endtask

    // Reference model of one instruction, checked against the retire port
    task automatic check_retire();
        core_pkg::inst_t w;
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        core_pkg::reg_addr_t rd;
        core_pkg::xlen_t a;
        core_pkg::xlen_t b;
        core_pkg::xlen_t opnd;
        core_pkg::xlen_t imm_i;
        core_pkg::xlen_t res;
        core_pkg::xlen_t addr;
        logic base;
        logic alt;
        logic wr;
        logic st;
        w = model_mem[model_pc[9:2]];
        opc = w[6:0];
        rd = w[11:7];
        f3 = w[14:12];
        f7 = w[31:25];
        a = model_regs[w[19:15]];
        b = model_regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        base = (f7 == 7'h00);
        alt = (f7 == 7'h20);
        res = '0;
        addr = '0;
        wr = 1'b0;
        st = 1'b0;
        if (opc == core_pkg::OPC_LOAD && f3 == 3'b010)
        begin
            addr = a + imm_i;
            res = model_mem[addr[9:2]];
            wr = 1'b1;
        end
        else if (opc == core_pkg::OPC_STORE && f3 == 3'b010)
        begin
            addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
            st = 1'b1;
        end
        else if (opc == core_pkg::OPC_OP || opc == core_pkg::OPC_OP_IMM)
        begin
            opnd = (opc == core_pkg::OPC_OP_IMM) ? imm_i : b;
            case (f3)
                3'b000: res = (alt && opc == core_pkg::OPC_OP) ? a - opnd : a + opnd;
                3'b001: res = a << opnd[4:0];
                3'b100: res = a ^ opnd;
                3'b101: res = alt ? shift_right_arith(a, opnd[4:0]) : a >> opnd[4:0];
                3'b110: res = a | opnd;
                3'b111: res = a & opnd;
                default: res = '0;
            endcase
            // Shifts check funct7 in both forms
            if (f3 == 3'b001)
                wr = base;
            else if (f3 == 3'b101)
                wr = base || alt;
            else if (f3 == 3'b010 || f3 == 3'b011)
                wr = 1'b0;
            else if (opc == core_pkg::OPC_OP_IMM)
                wr = 1'b1;
            else
                wr = base || (alt && f3 == 3'b000);
        end
        wr = wr && (rd != 0);
        compare("retire_pc", model_pc, retire_pc);
        compare("retire_rd_we", wr, retire_rd_we);
        compare("retire_mem_we", st, retire_mem_we);
        if (wr)
        begin
            compare("retire_rd", rd, retire_rd);
            compare("retire_data", res, retire_data);
            model_regs[rd] = res;
        end
        if (st)
        begin
            compare("retire_mem_addr", addr, retire_mem_addr);
            compare("retire_data", b, retire_data);
            model_mem[addr[9:2]] = b;
        end
        model_pc = model_pc + 32'd4;
    endtask

    // pause_after below zero runs straight through
    task automatic run_program(input int pause_after);
        load_program();
        raise_run();
        for (int k = 0; k < prog.size(); k++)
        begin
            do
            begin
                @(negedge clk);
            end
            while (!retire_valid);
            compare("retire spacing", gap, cycle - mark_cycle);
            check_retire();
            mark_cycle = cycle;
            gap = 5;
            if (k == pause_after)
            begin
                // Next instruction has already left IF
                @(posedge clk);
                @(posedge clk);
                run <= 1'b0;
            end
            else if (pause_after >= 0 && k == pause_after + 1)
            begin
                repeat (20)
                begin
                    @(negedge clk);
                    if (retire_valid)
                    begin
                        $display("Core retired an instruction while run was low");
                        fail_run();
                    end
                end
                raise_run();
            end
            else if (k == prog.size() - 1)
            begin
                @(posedge clk);
                run <= 1'b0;
            end
        end
    endtask

    task automatic reg_ops_test();
        reset_core();
        prog.delete();
        for (int i = 1; i <= 4; i++)
        begin
            prog.push_back(i_type(int'($urandom()), 3'b000, i, 0));
        end
        prog.push_back(r_type(7'h00, 3'b000, 5, 1, 2));
        prog.push_back(r_type(7'h20, 3'b000, 6, 1, 3));
        prog.push_back(r_type(7'h00, 3'b111, 7, 2, 4));
        prog.push_back(r_type(7'h00, 3'b110, 8, 3, 1));
        prog.push_back(r_type(7'h00, 3'b100, 9, 4, 2));
        prog.push_back(r_type(7'h00, 3'b001, 10, 1, 2));
        prog.push_back(r_type(7'h00, 3'b101, 11, 3, 4));
        prog.push_back(r_type(7'h20, 3'b101, 12, 1, 4));
        run_program(-1);
    endtask

    task automatic imm_ops_test();
        reset_core();
        prog.delete();
        prog.push_back(i_type(-1234, 3'b000, 1, 0));
        prog.push_back(i_type(1234, 3'b000, 2, 0));
        prog.push_back(i_type('h7f0, 3'b111, 3, 1));
        prog.push_back(i_type(-256, 3'b110, 4, 2));
        prog.push_back(i_type('h555, 3'b100, 5, 1));
        prog.push_back(i_type(7, 3'b001, 6, 1));
        prog.push_back(i_type(9, 3'b101, 7, 1));
        // Bit 10 of the immediate selects SRAI
        prog.push_back(i_type('h400 | 9, 3'b101, 8, 1));
        prog.push_back(i_type(-16, 3'b111, 9, 2));
        prog.push_back(i_type('h0f, 3'b110, 10, 1));
        prog.push_back(i_type(-1, 3'b100, 11, 2));
        prog.push_back(i_type(20, 3'b001, 12, 2));
        prog.push_back(i_type(3, 3'b101, 13, 2));
        prog.push_back(i_type('h400 | 3, 3'b101, 14, 2));
        run_program(-1);
    endtask

    task automatic mem_round_trip();
        reset_core();
        prog.delete();
        // Data area well above the program words
        prog.push_back(i_type('h200, 3'b000, 1, 0));
        for (int i = 2; i <= 4; i++)
        begin
            prog.push_back(i_type(int'($urandom()), 3'b000, i, 0));
        end
        prog.push_back(sw_inst(2, 1, 0));
        prog.push_back(sw_inst(3, 1, 4));
        prog.push_back(sw_inst(4, 1, -8));
        prog.push_back(sw_inst(1, 0, 'h300));
        prog.push_back(lw_inst(5, 1, 0));
        prog.push_back(lw_inst(6, 1, 4));
        prog.push_back(lw_inst(7, 1, -8));
        prog.push_back(lw_inst(8, 0, 'h300));
        run_program(-1);
    endtask

    task automatic x0_write_test();
        reset_core();
        prog.delete();
        prog.push_back(i_type(77, 3'b000, 1, 0));
        prog.push_back(i_type(5, 3'b000, 0, 1));
        prog.push_back(r_type(7'h00, 3'b000, 2, 0, 1));
        prog.push_back(r_type(7'h00, 3'b000, 3, 1, 0));
        run_program(-1);
    endtask

    task automatic run_control_test();
        reset_core();
        prog.delete();
        prog.push_back(i_type(10, 3'b000, 1, 0));
        // SLT is outside the subset
        prog.push_back(r_type(7'h00, 3'b010, 1, 1, 1));
        prog.push_back(32'hffff_ffff);
        prog.push_back(i_type(1, 3'b000, 2, 1));
        prog.push_back(i_type(2, 3'b000, 3, 1));
        prog.push_back(r_type(7'h00, 3'b000, 4, 2, 3));
        run_program(3);
    endtask

    initial
    begin
        void'($urandom(32'h25319df1));
        rst_n = 1'b0;
        run = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_wdata = '0;
        reg_ops_test();
        imm_ops_test();
        mem_round_trip();
        x0_write_test();
        run_control_test();
        if (error_count == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
